// ==== verification/memory_subsystem_stim.txt ====
# name kind iaddr daddr wmask wdata iexp dexp one_cycle
# kind I fetch, R data read, W data write, B fetch and data read; one_cycle 1 means a hit
fetch_cold_0 I 00000100 00000000 0 00000000 5a5a0100 00000000 0
fetch_hit_0 I 00000104 00000000 0 00000000 5a5a0104 00000000 1
fetch_cold_1 I 00000224 00000000 0 00000000 5a5a0224 00000000 0
fetch_hit_1 I 0000023c 00000000 0 00000000 5a5a023c 00000000 1
fetch_evict I 00000520 00000000 0 00000000 5a5a0520 00000000 0
fetch_back I 00000228 00000000 0 00000000 5a5a0228 00000000 0
read_cold R 00000000 00001040 0 00000000 00000000 5a5a1040 0
read_hit R 00000000 0000105c 0 00000000 00000000 5a5a105c 1
write_mask_lo W 00000000 00001044 3 1122aabb 00000000 00000000 1
read_merge_lo R 00000000 00001044 0 00000000 00000000 5a5aaabb 1
write_mask_hi W 00000000 00001048 c ccdd0000 00000000 00000000 1
read_merge_hi R 00000000 00001048 0 00000000 00000000 ccdd1048 1
write_mask_mid W 00000000 0000104c 6 00ee7700 00000000 00000000 1
read_merge_mid R 00000000 0000104c 0 00000000 00000000 5aee774c 1
write_full W 00000000 00001050 f deadbeef 00000000 00000000 1
read_conflict R 00000000 00002040 0 00000000 00000000 5a5a2040 0
read_refill R 00000000 00001050 0 00000000 00000000 deadbeef 0
read_refill_lo R 00000000 00001044 0 00000000 00000000 5a5aaabb 1
write_miss W 00000000 00003064 1 000000a5 00000000 00000000 0
read_after_wmiss R 00000000 00003064 0 00000000 00000000 5a5a30a5 1
both_miss B 00000460 00004080 0 00000000 5a5a0460 5a5a4080 0
both_miss_wb B 000006e8 00005070 0 00000000 5a5a06e8 5a5a5070 0
read_wb_check R 00000000 00003064 0 00000000 00000000 5a5a30a5 0

// ==== memory_subsystem.f ====
rtl/mem_pkg.sv
rtl/mem_port_if.sv
rtl/icache.sv
rtl/dcache.sv
rtl/arbiter.sv
rtl/memory_subsystem.sv
verification/pmem_model.sv
verification/memory_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: memory_subsystem

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/mem_port_if.sv
      - rtl/icache.sv
      - rtl/dcache.sv
      - rtl/arbiter.sv
      - rtl/memory_subsystem.sv
  - target: test
    files:
      - verification/pmem_model.sv
      - verification/memory_subsystem_tb.sv

// ==== verification/memory_subsystem_tb.sv ====
`timescale 1ns/10ps

module memory_subsystem_tb;

    localparam string stim_file = "verification/memory_subsystem_stim.txt";

    typedef struct {
        string              name;
        string              kind;
        mem_pkg::rv32i_word iaddr;
        mem_pkg::rv32i_word daddr;
        mem_pkg::byte_mask  wmask;
        mem_pkg::rv32i_word wdata;
        mem_pkg::rv32i_word iexp;
        mem_pkg::rv32i_word dexp;
        int                 one_cycle;  // 1 when the access must be a hit.
    } access_rec;

    logic               clk;
    logic               rst;
    mem_pkg::rv32i_word imem_address;
    logic               imem_read;
    logic               imem_resp;
    mem_pkg::rv32i_word imem_rdata;
    mem_pkg::rv32i_word dmem_address;
    logic               dmem_read;
    logic               dmem_write;
    mem_pkg::byte_mask  dmem_wmask;
    mem_pkg::rv32i_word dmem_wdata;
    logic               dmem_resp;
    mem_pkg::rv32i_word dmem_rdata;
    mem_pkg::rv32i_word pmem_address;
    logic               pmem_read;
    logic               pmem_write;
    mem_pkg::mem_line   pmem_wdata;
    logic               pmem_resp;
    mem_pkg::mem_line   pmem_rdata;

    access_rec recs [$];
    int        checks;
    int        errors;
    bit        records_ready;

    memory_subsystem #(
        .num_sets (8)
    ) i_memory_subsystem (
        .clk (clk), .rst (rst),
        .imem_address (imem_address), .imem_read (imem_read),
        .imem_resp (imem_resp), .imem_rdata (imem_rdata),
        .dmem_address (dmem_address), .dmem_read (dmem_read), .dmem_write (dmem_write),
        .dmem_wmask (dmem_wmask), .dmem_wdata (dmem_wdata),
        .dmem_resp (dmem_resp), .dmem_rdata (dmem_rdata),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_wdata (pmem_wdata), .pmem_resp (pmem_resp), .pmem_rdata (pmem_rdata)
    );

    pmem_model #(
        .seed (32'hdbb6)
    ) i_pmem_model (
        .clk (clk), .rst (rst), .address (pmem_address), .read (pmem_read),
        .write (pmem_write), .wdata (pmem_wdata), .resp (pmem_resp), .rdata (pmem_rdata)
    );

    always #20 clk = ~clk;  // 40 ns period.

    task automatic load_records();
        int        fd;
        int        count;
        string     text;
        access_rec r;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stim_file);
            errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.substr(0, 0) == "#") continue;
            count = $sscanf(text, "%s %s %h %h %h %h %h %h %d", r.name, r.kind, r.iaddr,
                            r.daddr, r.wmask, r.wdata, r.iexp, r.dexp, r.one_cycle);
            if (count != 9) begin
                $display("malformed stimulus record: %s", text);
                errors++;
                continue;
            end
            recs.push_back(r);
        end
        $fclose(fd);
    endtask

    // called on a falling edge and returns on the falling edge that sees resp.
    task automatic fetch_word(input access_rec r);
        int cycles;
        imem_address = r.iaddr;
        imem_read    = 1'b1;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!imem_resp);
        imem_read = 1'b0;
        checks++;
        assert (imem_rdata == r.iexp) else begin
            $display("Error %s fetch: expected %h, actual %h", r.name, r.iexp, imem_rdata);
            errors++;
        end
        if (r.one_cycle == 1) begin
            checks++;
            assert (cycles == 1) else begin
                $display("Error %s fetch latency: expected 1, actual %0d", r.name, cycles);
                errors++;
            end
        end
    endtask

    task automatic access_data(input access_rec r, input bit is_write);
        int cycles;
        dmem_address = r.daddr;
        dmem_read    = !is_write;
        dmem_write   = is_write;
        dmem_wmask   = r.wmask;
        dmem_wdata   = r.wdata;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dmem_resp);
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        if (!is_write) begin
            checks++;
            assert (dmem_rdata == r.dexp) else begin
                $display("Error %s data: expected %h, actual %h", r.name, r.dexp, dmem_rdata);
                errors++;
            end
        end
        if (r.one_cycle == 1) begin
            checks++;
            assert (cycles == 1) else begin
                $display("Error %s data latency: expected 1, actual %0d", r.name, cycles);
                errors++;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        imem_address  = '0;
        imem_read     = 1'b0;
        dmem_address  = '0;
        dmem_read     = 1'b0;
        dmem_write    = 1'b0;
        dmem_wmask    = '0;
        dmem_wdata    = '0;
        checks        = 0;
        errors        = 0;
        records_ready = 1'b0;
        load_records();
        records_ready = 1'b1;
        repeat (5) @(negedge clk);
        checks++;
        assert (!imem_resp && !dmem_resp && !pmem_read && !pmem_write) else begin
            $display("responses or memory requests are active at the end of reset");
            errors++;
        end
        rst = 1'b0;
        @(negedge clk);
        foreach (recs[i]) begin
            case (recs[i].kind)
                "I": fetch_word(recs[i]);
                "R": access_data(recs[i], 1'b0);
                "W": access_data(recs[i], 1'b1);
                "B": begin
                    fork
                        fetch_word(recs[i]);
                        access_data(recs[i], 1'b0);
                    join
                end
                default: begin
                    $display("unknown access kind %s in record %s", recs[i].kind, recs[i].name);
                    errors++;
                end
            endcase
            @(negedge clk);  // one idle cycle between records.
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // allows 300 cycles per record plus one record for reset.
    initial begin
        wait (records_ready);
        #((recs.size() + 1) * 300 * 40);
        $display("timeout, the accesses did not complete within %0d cycles",
                 (recs.size() + 1) * 300);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verification/pmem_model.sv ====
`timescale 1ns/10ps

module pmem_model #(
    parameter int unsigned seed = 32'hdbb6
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::rv32i_word address,
    input  logic               read,
    input  logic               write,
    input  mem_pkg::mem_line   wdata,
    output logic               resp,
    output mem_pkg::mem_line   rdata
);

    mem_pkg::mem_line lines [mem_pkg::rv32i_word];  // only lines that were written back.

    // every word holds its own byte address xor a fixed pattern.
    function automatic mem_pkg::mem_line initial_line(mem_pkg::rv32i_word line_address);
        mem_pkg::mem_line fill_data;
        for (int i = 0; i < 8; i++) begin
            fill_data[i*32 +: 32] = (line_address + 32'(4 * i)) ^ 32'h5a5a0000;
        end
        return fill_data;
    endfunction

    function automatic mem_pkg::mem_line read_line(mem_pkg::rv32i_word line_address);
        if (lines.exists(line_address)) begin
            return lines[line_address];
        end
        return initial_line(line_address);
    endfunction

    // answers one request at a time after 1 to 6 cycles.
    initial begin
        int delay;
        void'($urandom(seed));
        resp  = 1'b0;
        rdata = '0;
        forever begin
            @(posedge clk);
            if (!rst && (read || write)) begin
                delay = 1 + int'($urandom % 6);
                repeat (delay - 1) @(posedge clk);
                if (write) begin
                    lines[address] = wdata;
                end else begin
                    rdata <= read_line(address);
                end
                resp <= 1'b1;
                @(posedge clk);
                resp <= 1'b0;  // requester drops its request on this edge.
            end
        end
    end

endmodule

// ==== rtl/memory_subsystem.sv ====
`timescale 1ns/10ps

module memory_subsystem #(
    parameter int num_sets = 8
) (
    input  logic               clk,
    input  logic               rst,
    // instruction side.
    input  mem_pkg::rv32i_word imem_address,
    input  logic               imem_read,
    output logic               imem_resp,
    output mem_pkg::rv32i_word imem_rdata,
    // data side.
    input  mem_pkg::rv32i_word dmem_address,
    input  logic               dmem_read,
    input  logic               dmem_write,
    input  mem_pkg::byte_mask  dmem_wmask,
    input  mem_pkg::rv32i_word dmem_wdata,
    output logic               dmem_resp,
    output mem_pkg::rv32i_word dmem_rdata,
    // physical memory, line granular.
    output mem_pkg::rv32i_word pmem_address,
    output logic               pmem_read,
    output logic               pmem_write,
    output mem_pkg::mem_line   pmem_wdata,
    input  logic               pmem_resp,
    input  mem_pkg::mem_line   pmem_rdata
);

    mem_port_if icache_port ();
    mem_port_if dcache_port ();

    icache #(
        .num_sets (num_sets)
    ) i_icache (
        .clk     (clk),
        .rst     (rst),
        .address (imem_address),
        .read    (imem_read),
        .resp    (imem_resp),
        .rdata   (imem_rdata),
        .mem     (icache_port.requester)
    );

    dcache #(
        .num_sets (num_sets)
    ) i_dcache (
        .clk     (clk),
        .rst     (rst),
        .address (dmem_address),
        .read    (dmem_read),
        .write   (dmem_write),
        .wmask   (dmem_wmask),
        .wdata   (dmem_wdata),
        .resp    (dmem_resp),
        .rdata   (dmem_rdata),
        .mem     (dcache_port.requester)
    );

    arbiter i_arbiter (
        .clk          (clk),
        .rst          (rst),
        .icache       (icache_port.responder),
        .dcache       (dcache_port.responder),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

endmodule

// ==== rtl/arbiter.sv ====
`timescale 1ns/10ps

module arbiter (
    input  logic               clk,
    input  logic               rst,
    mem_port_if.responder      icache,
    mem_port_if.responder      dcache,
    output mem_pkg::rv32i_word pmem_address,
    output logic               pmem_read,
    output logic               pmem_write,
    output mem_pkg::mem_line   pmem_wdata,
    input  logic               pmem_resp,
    input  mem_pkg::mem_line   pmem_rdata
);

    enum logic {icache_side, dcache_side} grant;

    logic icache_req;
    logic dcache_req;

    assign icache_req = icache.read || icache.write;
    assign dcache_req = dcache.read || dcache.write;

    // owner keeps the port while it requests.
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= icache_side;
        end else begin
            case (grant)
                icache_side: if (!icache_req && dcache_req) grant <= dcache_side;
                dcache_side: if (!dcache_req && icache_req) grant <= icache_side;
                default:     grant <= icache_side;
            endcase
        end
    end

    always_comb begin
        icache.resp  = 1'b0;  // idle side sees nothing.
        icache.rdata = '0;
        dcache.resp  = 1'b0;
        dcache.rdata = '0;
        case (grant)
            dcache_side: begin
                pmem_address = dcache.address;
                pmem_read    = dcache.read;
                pmem_write   = dcache.write;
                pmem_wdata   = dcache.wdata;
                dcache.resp  = pmem_resp;
                dcache.rdata = pmem_rdata;
            end
            default: begin
                pmem_address = icache.address;
                pmem_read    = icache.read;
                pmem_write   = icache.write;
                pmem_wdata   = icache.wdata;
                icache.resp  = pmem_resp;
                icache.rdata = pmem_rdata;
            end
        endcase
    end

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/10ps

module dcache #(
    parameter int num_sets = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::rv32i_word address,
    input  logic               read,
    input  logic               write,
    input  mem_pkg::byte_mask  wmask,
    input  mem_pkg::rv32i_word wdata,
    output logic               resp,
    output mem_pkg::rv32i_word rdata,
    mem_port_if.requester      mem
);

    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits = 32 - mem_pkg::offset_bits - index_bits;

    enum logic [1:0] {idle, write_back, fill} state;

    logic [tag_bits-1:0]               tag_array [num_sets];
    mem_pkg::mem_line                  line_array [num_sets];
    logic [num_sets-1:0]               valid;
    logic [num_sets-1:0]               dirty;
    logic [index_bits-1:0]             index;
    logic [tag_bits-1:0]               tag;
    logic [mem_pkg::word_sel_bits-1:0] word_sel;
    logic                              req;
    logic                              hit;
    logic                              take_hit;
    mem_pkg::rv32i_word                merged;

    assign index    = address[mem_pkg::offset_bits +: index_bits];
    assign tag      = address[31 -: tag_bits];
    assign word_sel = address[2 +: mem_pkg::word_sel_bits];
    assign req      = read || write;
    assign hit      = valid[index] && (tag_array[index] == tag);
    assign take_hit = (state == idle) && req && !resp && hit;

    // write-back goes to the victim's line, the fill to the requested one.
    assign mem.address = (state == write_back) ?
                         {tag_array[index], index, {mem_pkg::offset_bits{1'b0}}} :
                         {tag, index, {mem_pkg::offset_bits{1'b0}}};
    assign mem.read    = (state == fill);
    assign mem.write   = (state == write_back);
    assign mem.wdata   = line_array[index];

    // stored word with the enabled bytes replaced.
    always_comb begin
        merged = line_array[index][word_sel*32 +: 32];
        for (int i = 0; i < 4; i++) begin
            if (wmask[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            valid <= '0;
            dirty <= '0;
            resp  <= 1'b0;
        end else begin
            resp <= 1'b0;
            case (state)
                idle: begin
                    if (take_hit) begin
                        resp <= 1'b1;
                        if (write) begin
                            dirty[index] <= 1'b1;
                        end
                    end else if (req && !resp && !hit) begin
                        state <= (valid[index] && dirty[index]) ? write_back : fill;
                    end
                end
                write_back: begin
                    if (mem.resp) begin
                        state <= fill;  // request stays up so the grant is kept.
                    end
                end
                fill: begin
                    if (mem.resp) begin
                        valid[index] <= 1'b1;
                        dirty[index] <= 1'b0;
                        state        <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fill && mem.resp) begin
            line_array[index] <= mem.rdata;
            tag_array[index]  <= tag;
        end else if (take_hit && write) begin
            line_array[index][word_sel*32 +: 32] <= merged;
        end
        if (take_hit) begin
            rdata <= line_array[index][word_sel*32 +: 32];
        end
    end

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/10ps

module icache #(
    parameter int num_sets = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::rv32i_word address,
    input  logic               read,
    output logic               resp,
    output mem_pkg::rv32i_word rdata,
    mem_port_if.requester      mem
);

    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits = 32 - mem_pkg::offset_bits - index_bits;

    enum logic {idle, fill} state;

    logic [tag_bits-1:0]               tag_array [num_sets];
    mem_pkg::mem_line                  line_array [num_sets];
    logic [num_sets-1:0]               valid;
    logic [index_bits-1:0]             index;
    logic [tag_bits-1:0]               tag;
    logic [mem_pkg::word_sel_bits-1:0] word_sel;
    logic                              hit;
    logic                              take_hit;

    assign index    = address[mem_pkg::offset_bits +: index_bits];
    assign tag      = address[31 -: tag_bits];
    assign word_sel = address[2 +: mem_pkg::word_sel_bits];
    assign hit      = valid[index] && (tag_array[index] == tag);
    assign take_hit = (state == idle) && read && !resp && hit;  // skip the cycle of our own resp.

    assign mem.address = {tag, index, {mem_pkg::offset_bits{1'b0}}};
    assign mem.read    = (state == fill);
    assign mem.write   = 1'b0;  // nothing is ever written back.
    assign mem.wdata   = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            valid <= '0;
            resp  <= 1'b0;
        end else begin
            resp <= 1'b0;
            case (state)
                idle: begin
                    if (take_hit) begin
                        resp <= 1'b1;
                    end else if (read && !resp && !hit) begin
                        state <= fill;
                    end
                end
                fill: begin
                    if (mem.resp) begin
                        valid[index] <= 1'b1;
                        state        <= idle;  // the hit path answers next.
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fill && mem.resp) begin
            line_array[index] <= mem.rdata;
            tag_array[index]  <= tag;
        end
        if (take_hit) begin
            rdata <= line_array[index][word_sel*32 +: 32];
        end
    end

endmodule

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/10ps

interface mem_port_if;

    mem_pkg::rv32i_word address;  // line aligned.
    logic               read;
    logic               write;
    mem_pkg::mem_line   wdata;
    logic               resp;     // one-cycle pulse ending a request.
    mem_pkg::mem_line   rdata;    // valid with resp on a read.

    modport requester (
        output address, read, write, wdata,
        input  resp, rdata
    );

    modport responder (
        input  address, read, write, wdata,
        output resp, rdata
    );

endinterface

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // line geometry.
    localparam int offset_bits = 5;    // byte offset within a 32-byte line.
    localparam int word_sel_bits = 3;  // eight words per line.

    // data word, instruction word and byte address.
    typedef logic [31:0] rv32i_word;

    // one cache line as moved over a memory port.
    typedef logic [255:0] mem_line;

    // byte enables for a word write with bit 0 on the lowest byte.
    typedef logic [3:0] byte_mask;

endpackage
